// ==== rvPkg.sv ====
package rvPkg;

    // Data path width is fixed by RV32I.
    typedef logic [31:0] word_t;

    // Register numbers x0 to x31.
    typedef logic [4:0] regAddr_t;

    // Major opcodes that the core executes. Any other encoding is illegal.
    typedef enum logic [6:0] {
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_IMM   = 7'b0010011,
        OP_REG   = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10  // Operand B straight through, for LUI.
    } aluOp_e;

    // funct7 encodings that matter to OP and the shifts.
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage

// ==== InstLatch.sv ====
module InstLatch #(
    parameter int                  PC_WIDTH = 12,
    parameter logic [PC_WIDTH-1:0] RESET_PC = '0
) (
    input  logic                i_Clock,
    input  logic                i_rstN,
    input  logic                i_InstValid,
    input  rvPkg::word_t        i_Inst,
    output logic                o_Valid,
    output rvPkg::word_t        o_Inst,
    output logic [PC_WIDTH-1:0] o_Pc
);

    logic [PC_WIDTH-1:0] nextPc;  // Address given to the next accepted instruction.

    // Valid lasts one cycle per strobe, and the PC moves with it.
    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_Valid <= 1'b0;
            o_Pc    <= RESET_PC;
            nextPc  <= RESET_PC;
        end else begin
            o_Valid <= i_InstValid;
            if (i_InstValid) begin
                o_Pc   <= nextPc;
                nextPc <= nextPc + PC_WIDTH'(4);  // Wraps at PC_WIDTH.
            end
        end
    end

    always_ff @(posedge i_Clock) begin
        if (i_InstValid) begin
            o_Inst <= i_Inst;
        end
    end

endmodule

// ==== Decoder_RV32I.sv ====
module Decoder_RV32I (
    input  rvPkg::word_t    i_Inst,
    output rvPkg::opcode_e  o_Op,
    output rvPkg::regAddr_t o_Rs1,
    output rvPkg::regAddr_t o_Rs2,
    output rvPkg::regAddr_t o_Rd,
    output rvPkg::word_t    o_Imm,
    output rvPkg::aluOp_e   o_AluOp,
    output logic            o_UseImm,
    output logic            o_UsePc,
    output logic            o_RegWrite,
    output logic            o_Illegal
);

    logic [2:0]   funct3;
    logic [6:0]   funct7;
    rvPkg::word_t immI;
    rvPkg::word_t immU;

    assign o_Op   = rvPkg::opcode_e'(i_Inst[6:0]);
    assign o_Rd   = i_Inst[11:7];
    assign funct3 = i_Inst[14:12];
    assign o_Rs1  = i_Inst[19:15];
    assign o_Rs2  = i_Inst[24:20];
    assign funct7 = i_Inst[31:25];

    assign immI = {{20{i_Inst[31]}}, i_Inst[31:20]};  // Low 5 bits double as shamt.
    assign immU = {i_Inst[31:12], 12'b0};

    always_comb begin
        logic bad;
        bad        = 1'b0;
        o_Imm      = immI;
        o_AluOp    = rvPkg::ALU_ADD;
        o_UseImm   = 1'b0;
        o_UsePc    = 1'b0;
        case (o_Op)
            rvPkg::OP_LUI: begin
                o_Imm    = immU;
                o_AluOp  = rvPkg::ALU_PASSB;
                o_UseImm = 1'b1;
            end
            rvPkg::OP_AUIPC: begin
                o_Imm    = immU;
                o_UseImm = 1'b1;
                o_UsePc  = 1'b1;
            end
            rvPkg::OP_IMM: begin
                o_UseImm = 1'b1;
                case (funct3)
                    3'b000: o_AluOp = rvPkg::ALU_ADD;
                    3'b010: o_AluOp = rvPkg::ALU_SLT;
                    3'b011: o_AluOp = rvPkg::ALU_SLTU;
                    3'b100: o_AluOp = rvPkg::ALU_XOR;
                    3'b110: o_AluOp = rvPkg::ALU_OR;
                    3'b111: o_AluOp = rvPkg::ALU_AND;
                    3'b001: begin
                        o_AluOp = rvPkg::ALU_SLL;
                        bad     = (funct7 != rvPkg::FUNCT7_BASE);
                    end
                    default: begin  // SRLI and SRAI differ only in funct7.
                        o_AluOp = (funct7 == rvPkg::FUNCT7_ALT) ? rvPkg::ALU_SRA
                                                                : rvPkg::ALU_SRL;
                        bad     = (funct7 != rvPkg::FUNCT7_BASE)
                               && (funct7 != rvPkg::FUNCT7_ALT);
                    end
                endcase
            end
            rvPkg::OP_REG: begin
                if (funct7 == rvPkg::FUNCT7_BASE) begin
                    case (funct3)
                        3'b000:  o_AluOp = rvPkg::ALU_ADD;
                        3'b001:  o_AluOp = rvPkg::ALU_SLL;
                        3'b010:  o_AluOp = rvPkg::ALU_SLT;
                        3'b011:  o_AluOp = rvPkg::ALU_SLTU;
                        3'b100:  o_AluOp = rvPkg::ALU_XOR;
                        3'b101:  o_AluOp = rvPkg::ALU_SRL;
                        3'b110:  o_AluOp = rvPkg::ALU_OR;
                        default: o_AluOp = rvPkg::ALU_AND;
                    endcase
                end else if (funct7 == rvPkg::FUNCT7_ALT && funct3 == 3'b000) begin
                    o_AluOp = rvPkg::ALU_SUB;
                end else if (funct7 == rvPkg::FUNCT7_ALT && funct3 == 3'b101) begin
                    o_AluOp = rvPkg::ALU_SRA;
                end else begin
                    bad = 1'b1;
                end
            end
            default: bad = 1'b1;  // Loads, stores, branches and the rest.
        endcase
        o_Illegal  = bad;
        o_RegWrite = !bad;
    end

endmodule

// ==== RegisterFile.sv ====
module RegisterFile (
    input  logic            i_Clock,
    input  logic            i_rstN,
    input  rvPkg::regAddr_t i_Rs1,
    input  rvPkg::regAddr_t i_Rs2,
    output rvPkg::word_t    o_Rs1Data,
    output rvPkg::word_t    o_Rs2Data,
    input  logic            i_We,
    input  rvPkg::regAddr_t i_Rd,
    input  rvPkg::word_t    i_WrData
);

    rvPkg::word_t regs [32];

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_We && i_Rd != '0) begin  // x0 is hardwired to zero.
            regs[i_Rd] <= i_WrData;
        end
    end

    // Reads are combinational, so a write shows up the cycle after its edge.
    assign o_Rs1Data = regs[i_Rs1];
    assign o_Rs2Data = regs[i_Rs2];

    // The write-back path drops writes to x0 before they reach this port.
    ZeroRegister: assert property (@(posedge i_Clock) disable iff (!i_rstN)
        !(i_We && i_Rd == '0))
        else $error("RegisterFile: write enable asserted for x0.");

endmodule

// ==== IntAlu.sv ====
module IntAlu #(
    parameter int PC_WIDTH = 12
) (
    input  rvPkg::word_t        i_Rs1Data,
    input  rvPkg::word_t        i_Rs2Data,
    input  rvPkg::word_t        i_Imm,
    input  logic [PC_WIDTH-1:0] i_Pc,
    input  rvPkg::aluOp_e       i_AluOp,
    input  logic                i_UseImm,
    input  logic                i_UsePc,
    output rvPkg::word_t        o_Result
);

    rvPkg::word_t opA;
    rvPkg::word_t opB;
    logic [4:0]   shamt;

    assign opA   = i_UsePc ? rvPkg::word_t'(i_Pc) : i_Rs1Data;  // PC zero-extended.
    assign opB   = i_UseImm ? i_Imm : i_Rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        case (i_AluOp)
            rvPkg::ALU_ADD:   o_Result = opA + opB;
            rvPkg::ALU_SUB:   o_Result = opA - opB;
            rvPkg::ALU_SLL:   o_Result = opA << shamt;
            rvPkg::ALU_SLT: begin
                o_Result = {31'b0, $signed(opA) < $signed(opB)};
            end
            rvPkg::ALU_SLTU:  o_Result = {31'b0, opA < opB};
            rvPkg::ALU_XOR:   o_Result = opA ^ opB;
            rvPkg::ALU_SRL:   o_Result = opA >> shamt;
            rvPkg::ALU_SRA:   o_Result = rvPkg::word_t'($signed(opA) >>> shamt);
            rvPkg::ALU_OR:    o_Result = opA | opB;
            rvPkg::ALU_AND:   o_Result = opA & opB;
            rvPkg::ALU_PASSB: o_Result = opB;
            default:          o_Result = '0;  // Unused encodings.
        endcase
    end

endmodule

// ==== TraceWriter.sv ====
module TraceWriter #(
    parameter int PC_WIDTH = 12
) (
    input  logic                i_Clock,
    input  logic                i_rstN,
    input  logic                i_Valid,
    input  logic [PC_WIDTH-1:0] i_Pc,
    input  rvPkg::word_t        i_Inst,
    input  rvPkg::regAddr_t     i_Rd,
    input  logic                i_RegWrite,
    input  logic                i_Illegal,
    input  rvPkg::word_t        i_Result,
    output logic                o_RfWe,
    output rvPkg::regAddr_t     o_RfRd,
    output rvPkg::word_t        o_RfData,
    output logic                o_TraceValid,
    output logic [PC_WIDTH-1:0] o_TracePc,
    output rvPkg::word_t        o_TraceInst,
    output rvPkg::regAddr_t     o_TraceRd,
    output logic                o_TraceWe,
    output rvPkg::word_t        o_TraceData,
    output logic                o_TraceIllegal
);

    // Write-back lands at the same edge that registers the trace record.
    assign o_RfWe   = i_Valid && i_RegWrite && (i_Rd != '0);
    assign o_RfRd   = i_Rd;
    assign o_RfData = i_Result;

    always_ff @(posedge i_Clock or negedge i_rstN) begin
        if (!i_rstN) begin
            o_TraceValid   <= 1'b0;
            o_TraceWe      <= 1'b0;
            o_TraceIllegal <= 1'b0;
        end else begin
            o_TraceValid   <= i_Valid;
            o_TraceWe      <= o_RfWe;  // Low for x0 and for illegal instructions.
            o_TraceIllegal <= i_Valid && i_Illegal;
        end
    end

    always_ff @(posedge i_Clock) begin
        if (i_Valid) begin
            o_TracePc   <= i_Pc;
            o_TraceInst <= i_Inst;
            o_TraceRd   <= i_Rd;
            o_TraceData <= i_Result;
        end
    end

    // Back-to-back records belong to instructions at consecutive addresses.
    BackToBack: assert property (@(posedge i_Clock) disable iff (!i_rstN)
        o_TraceValid && $past(o_TraceValid)
            |-> o_TracePc == $past(o_TracePc) + PC_WIDTH'(4))
        else $error("TraceWriter: back-to-back records with non-consecutive PCs.");

endmodule

// ==== CoreTop.sv ====
module CoreTop #(
    parameter int                  PC_WIDTH = 12,
    parameter logic [PC_WIDTH-1:0] RESET_PC = '0
) (
    input  logic                i_Clock,
    input  logic                i_rstN,
    input  logic                i_InstValid,
    input  rvPkg::word_t        i_Inst,
    output logic                o_TraceValid,
    output logic [PC_WIDTH-1:0] o_TracePc,
    output rvPkg::word_t        o_TraceInst,
    output rvPkg::regAddr_t     o_TraceRd,
    output logic                o_TraceWe,
    output rvPkg::word_t        o_TraceData,
    output logic                o_TraceIllegal
);

    logic                latValid;
    rvPkg::word_t        latInst;
    logic [PC_WIDTH-1:0] latPc;

    rvPkg::regAddr_t     decRs1, decRs2, decRd;
    rvPkg::word_t        decImm;
    rvPkg::aluOp_e       decAluOp;
    logic                decUseImm, decUsePc, decRegWrite, decIllegal;

    rvPkg::word_t        rs1Data, rs2Data, aluResult;
    logic                rfWe;
    rvPkg::regAddr_t     rfRd;
    rvPkg::word_t        rfData;

    InstLatch #(.PC_WIDTH(PC_WIDTH), .RESET_PC(RESET_PC)) latch0 (
        .i_Clock(i_Clock), .i_rstN(i_rstN), .i_InstValid(i_InstValid), .i_Inst(i_Inst),
        .o_Valid(latValid), .o_Inst(latInst), .o_Pc(latPc));

    Decoder_RV32I dec0 (
        .i_Inst(latInst), .o_Op(), .o_Rs1(decRs1), .o_Rs2(decRs2), .o_Rd(decRd),
        .o_Imm(decImm), .o_AluOp(decAluOp), .o_UseImm(decUseImm), .o_UsePc(decUsePc),
        .o_RegWrite(decRegWrite), .o_Illegal(decIllegal));

    RegisterFile rf0 (
        .i_Clock(i_Clock), .i_rstN(i_rstN), .i_Rs1(decRs1), .i_Rs2(decRs2),
        .o_Rs1Data(rs1Data), .o_Rs2Data(rs2Data),
        .i_We(rfWe), .i_Rd(rfRd), .i_WrData(rfData));

    IntAlu #(.PC_WIDTH(PC_WIDTH)) alu0 (
        .i_Rs1Data(rs1Data), .i_Rs2Data(rs2Data), .i_Imm(decImm), .i_Pc(latPc),
        .i_AluOp(decAluOp), .i_UseImm(decUseImm), .i_UsePc(decUsePc),
        .o_Result(aluResult));

    TraceWriter #(.PC_WIDTH(PC_WIDTH)) trace0 (
        .i_Clock(i_Clock), .i_rstN(i_rstN), .i_Valid(latValid), .i_Pc(latPc),
        .i_Inst(latInst), .i_Rd(decRd), .i_RegWrite(decRegWrite), .i_Illegal(decIllegal),
        .i_Result(aluResult), .o_RfWe(rfWe), .o_RfRd(rfRd), .o_RfData(rfData),
        .o_TraceValid(o_TraceValid), .o_TracePc(o_TracePc), .o_TraceInst(o_TraceInst),
        .o_TraceRd(o_TraceRd), .o_TraceWe(o_TraceWe), .o_TraceData(o_TraceData),
        .o_TraceIllegal(o_TraceIllegal));

endmodule

// ==== tb_CoreTop.sv ====
module tb_CoreTop;

    localparam int PC_WIDTH = 12;

    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_REG   = 7'b0110011;

    logic                i_Clock;
    logic                i_rstN;
    logic                i_InstValid;
    logic [31:0]         i_Inst;
    logic                o_TraceValid;
    logic [PC_WIDTH-1:0] o_TracePc;
    logic [31:0]         o_TraceInst;
    logic [4:0]          o_TraceRd;
    logic                o_TraceWe;
    logic [31:0]         o_TraceData;
    logic                o_TraceIllegal;

    logic [31:0]         progInst[$];  // Stimulus table, one entry per strobe.
    int                  progGap[$];   // Idle cycles after each strobe.

    int                  expCycle[$];
    logic [PC_WIDTH-1:0] expPc[$];
    logic [31:0]         expInst[$];
    logic                expWe[$];
    logic [31:0]         expData[$];
    logic                expIllegal[$];

    logic [31:0]         shadowRegs[32];
    logic [PC_WIDTH-1:0] modelPc;
    logic [31:0]         rngState;
    int                  cycleCount = 0;
    int                  cycleLimit = 0;
    int                  checkCount = 0;
    int                  errorCount = 0;

    CoreTop dut0 (
        .i_Clock(i_Clock), .i_rstN(i_rstN), .i_InstValid(i_InstValid), .i_Inst(i_Inst),
        .o_TraceValid(o_TraceValid), .o_TracePc(o_TracePc), .o_TraceInst(o_TraceInst),
        .o_TraceRd(o_TraceRd), .o_TraceWe(o_TraceWe), .o_TraceData(o_TraceData),
        .o_TraceIllegal(o_TraceIllegal));

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] makeUpper(input logic [6:0] opc, input logic [4:0] rd,
                                              input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] immOp(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] regOp(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    task automatic addEntry(input logic [31:0] inst, input int gap);
        progInst.push_back(inst);
        progGap.push_back(gap);
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at time %0t: %s is %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    // RV32I reference for the supported subset; updates the shadow registers.
    task automatic runModel(input logic [31:0] inst, output logic [31:0] result,
                            output logic illegal);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        rd      = inst[11:7];
        f3      = inst[14:12];
        f7      = inst[31:25];
        alt     = (f7 == 7'h20);
        a       = shadowRegs[inst[19:15]];
        b       = shadowRegs[inst[24:20]];
        result  = 32'h0;
        illegal = 1'b0;
        if (inst[6:0] == OPC_LUI) begin
            result = {inst[31:12], 12'h000};
        end else if (inst[6:0] == OPC_AUIPC) begin
            result = {inst[31:12], 12'h000} + {{(32-PC_WIDTH){1'b0}}, modelPc};
        end else if (inst[6:0] == OPC_IMM || inst[6:0] == OPC_REG) begin
            if (inst[6:0] == OPC_IMM) begin
                b = {{20{inst[31]}}, inst[31:20]};
                if (f3 == 3'd1) illegal = (f7 != 7'h00);
                if (f3 == 3'd5) illegal = (f7 != 7'h00) && !alt;
                alt = alt && (f3 == 3'd5);  // Only SRAI has an alternate form.
            end else begin
                illegal = (f7 != 7'h00) && !(alt && (f3 == 3'd0 || f3 == 3'd5));
            end
            case (f3)
                3'd0: result = alt ? a - b : a + b;
                3'd1: result = a << b[4:0];
                3'd2: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: result = (a < b) ? 32'd1 : 32'd0;
                3'd4: result = a ^ b;
                3'd5: begin
                    if (alt) result = $signed(a) >>> b[4:0];
                    else result = a >> b[4:0];
                end
                3'd6: result = a | b;
                default: result = a & b;
            endcase
        end else begin
            illegal = 1'b1;
        end
        if (!illegal && rd != 5'd0) shadowRegs[rd] = result;
    endtask

    task automatic predictRecord(input logic [31:0] inst);
        logic [31:0] result;
        logic        illegal;
        runModel(inst, result, illegal);
        expCycle.push_back(cycleCount + 3);  // Two cycles after the strobe cycle.
        expPc.push_back(modelPc);
        expInst.push_back(inst);
        expWe.push_back(!illegal && inst[11:7] != 5'd0);
        expData.push_back(result);
        expIllegal.push_back(illegal);
        modelPc = modelPc + PC_WIDTH'(4);
    endtask

    task automatic buildProgram();
        logic [31:0] rnd;
        logic [2:0]  f3;
        addEntry(makeUpper(OPC_LUI, 5'd1, 20'h12345), 1);
        addEntry(makeUpper(OPC_AUIPC, 5'd2, 20'h00001), 0);
        addEntry(makeUpper(OPC_LUI, 5'd3, 20'hfffff), 2);
        addEntry(makeUpper(OPC_AUIPC, 5'd4, 20'h80000), 0);
        addEntry(immOp(3'd0, 5'd5, 5'd0, 12'hfff), 0);
        addEntry(immOp(3'd0, 5'd6, 5'd1, 12'h7ff), 1);
        addEntry(immOp(3'd0, 5'd7, 5'd5, 12'h800), 0);
        addEntry(immOp(3'd2, 5'd8, 5'd5, 12'h000), 0);
        addEntry(immOp(3'd2, 5'd9, 5'd6, 12'hffb), 0);
        addEntry(immOp(3'd3, 5'd10, 5'd6, 12'hfff), 0);  // SLTIU against all ones.
        addEntry(immOp(3'd3, 5'd11, 5'd5, 12'hfff), 1);
        addEntry(immOp(3'd4, 5'd12, 5'd1, 12'hfff), 0);
        addEntry(immOp(3'd6, 5'd13, 5'd3, 12'h0f0), 0);
        addEntry(immOp(3'd7, 5'd14, 5'd6, 12'h0f0), 0);
        addEntry(immOp(3'd1, 5'd15, 5'd6, {7'h00, 5'd4}), 0);
        addEntry(immOp(3'd5, 5'd16, 5'd3, {7'h00, 5'd8}), 0);
        addEntry(immOp(3'd5, 5'd17, 5'd3, {7'h20, 5'd8}), 0);
        addEntry(immOp(3'd5, 5'd18, 5'd5, {7'h20, 5'd31}), 2);
        addEntry(regOp(7'h00, 3'd0, 5'd19, 5'd1, 5'd6), 0);
        addEntry(regOp(7'h20, 3'd0, 5'd20, 5'd19, 5'd5), 0);  // Uses x19 back to back.
        addEntry(regOp(7'h00, 3'd1, 5'd21, 5'd20, 5'd8), 0);
        addEntry(regOp(7'h00, 3'd2, 5'd22, 5'd3, 5'd1), 0);
        addEntry(regOp(7'h00, 3'd3, 5'd23, 5'd3, 5'd1), 1);
        addEntry(regOp(7'h00, 3'd4, 5'd24, 5'd21, 5'd12), 0);
        addEntry(regOp(7'h00, 3'd5, 5'd25, 5'd3, 5'd15), 0);
        addEntry(regOp(7'h20, 3'd5, 5'd26, 5'd3, 5'd15), 0);
        addEntry(regOp(7'h00, 3'd6, 5'd27, 5'd24, 5'd25), 0);
        addEntry(regOp(7'h00, 3'd7, 5'd28, 5'd27, 5'd17), 1);
        addEntry(immOp(3'd0, 5'd0, 5'd1, 12'h005), 0);
        addEntry(regOp(7'h00, 3'd0, 5'd29, 5'd0, 5'd0), 0);
        addEntry(regOp(7'h20, 3'd0, 5'd0, 5'd5, 5'd1), 1);
        addEntry(regOp(7'h00, 3'd6, 5'd30, 5'd0, 5'd6), 0);
        addEntry(regOp(7'h01, 3'd0, 5'd1, 5'd5, 5'd6), 0);  // Bad funct7 on OP.
        addEntry({12'h004, 5'd2, 3'b010, 5'd2, 7'b0000011}, 0);  // Load.
        addEntry(immOp(3'd1, 5'd4, 5'd1, {7'h20, 5'd3}), 1);
        addEntry(32'h00628463, 0);  // Branch.
        addEntry(regOp(7'h00, 3'd0, 5'd31, 5'd1, 5'd2), 0);
        addEntry(regOp(7'h00, 3'd0, 5'd9, 5'd4, 5'd8), 2);
        for (int k = 0; k < 16; k++) begin
            rngState = nextRandom(rngState);
            rnd      = rngState;
            case (rnd[1:0])
                2'd0:    f3 = 3'd0;
                2'd1:    f3 = 3'd4;
                default: f3 = 3'd6;
            endcase
            addEntry(immOp(f3, {1'b0, rnd[5:2]}, {1'b0, rnd[9:6]}, rnd[21:10]),
                     int'(rnd[31:30]) % 3);
        end
    endtask

    initial begin
        i_Clock = 1'b0;
        forever #2 i_Clock = ~i_Clock;
    end

    always @(negedge i_Clock) begin : traceMonitor
        logic                expValid;
        logic [31:0]         inst;
        logic [PC_WIDTH-1:0] pc;
        logic                we;
        logic [31:0]         data;
        logic                ill;
        cycleCount = cycleCount + 1;
        expValid   = 1'b0;
        if (expCycle.size() > 0) expValid = (expCycle[0] == cycleCount);
        checkValue(32'(o_TraceValid), 32'(expValid), "trace valid");
        if (expValid) begin
            void'(expCycle.pop_front());
            inst = expInst.pop_front();
            pc   = expPc.pop_front();
            we   = expWe.pop_front();
            data = expData.pop_front();
            ill  = expIllegal.pop_front();
            if (o_TraceValid) begin
                checkValue(32'(o_TracePc), 32'(pc), "trace pc");
                checkValue(o_TraceInst, inst, "trace instruction");
                checkValue(32'(o_TraceRd), 32'(inst[11:7]), "trace rd");
                checkValue(32'(o_TraceWe), 32'(we), "trace write enable");
                checkValue(32'(o_TraceIllegal), 32'(ill), "trace illegal flag");
                if (!ill) checkValue(o_TraceData, data, "trace data");
            end
        end
    end

    initial begin
        @(posedge i_Clock);
        while (cycleCount < cycleLimit) @(posedge i_Clock);
        $display("Timeout: the run did not finish within %0d cycles.", cycleLimit);
        $display("Something failed");
        $finish;
    end

    initial begin
        i_rstN      = 1'b0;
        i_InstValid = 1'b0;
        i_Inst      = 32'h0;
        modelPc     = '0;
        rngState    = 32'h19a6;
        for (int r = 0; r < 32; r++) shadowRegs[r] = 32'h0;
        buildProgram();
        cycleLimit = progInst.size() * 3 + 50;
        repeat (3) @(posedge i_Clock);
        i_rstN <= 1'b1;
        for (int n = 0; n < progInst.size(); n++) begin
            @(posedge i_Clock);
            i_InstValid <= 1'b1;
            i_Inst      <= progInst[n];
            predictRecord(progInst[n]);
            repeat (progGap[n]) begin
                @(posedge i_Clock);
                i_InstValid <= 1'b0;
            end
        end
        @(posedge i_Clock);
        i_InstValid <= 1'b0;
        while (expCycle.size() > 0) @(negedge i_Clock);
        repeat (4) @(negedge i_Clock);  // Trace must stay quiet after the last record.
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rvPkg.sv
InstLatch.sv
Decoder_RV32I.sv
RegisterFile.sv
IntAlu.sv
TraceWriter.sv
CoreTop.sv
tb_CoreTop.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_CoreTop
FILELIST   = vlog.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Something failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails if the simulator exits badly or the log holds the fail message.
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
